/* verilog/padPkg.sv */
/* Counter-mode pad package
   Sizes, line and pipeline slot types, and the toy round constants */
package padPkg;

    // ----------------------------------------
    // Line geometry
    // ----------------------------------------
    localparam int LANES     = 2;
    localparam int LANE_BITS = 128;
    localparam int LINE_BITS = LANES * LANE_BITS;
    localparam int SEED_BITS = 32;
    localparam int KEY_BITS  = 128;

    // Seed copies needed to fill one lane
    localparam int SEED_REPS = LANE_BITS / SEED_BITS;

    // ----------------------------------------
    // Pipeline and queue sizing
    // ----------------------------------------
    // Round count also fixes the pad latency
    localparam int ROUNDS = 12;
    // Bits of rotation per round step
    localparam int ROT_STEP = 8;
    // Holds more than the 13 lines that can be in flight
    localparam int QUEUE_DEPTH    = 16;
    localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);

    // Plaintext, pad or ciphertext line
    typedef logic [LINE_BITS-1:0] line_t;

    // Request as it arrives at the top
    typedef struct packed {
        logic                 valid;
        logic [SEED_BITS-1:0] seed;
        line_t                plain;
    } cipherReq_t;

    // One pipeline slot, key captured at entry
    typedef struct packed {
        logic                valid;
        line_t               state;
        logic [KEY_BITS-1:0] key;
    } padStage_t;

endpackage

/* verilog/padGenerator.sv */
/* Keystream pad generator
   Twelve-stage round pipeline that turns a seed and a key into a two-lane pad */
module padGenerator
    import padPkg::*;
(
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic [SEED_BITS-1:0] Seed,
    input  logic                 SeedValid,
    input  logic [KEY_BITS-1:0]  Key,
    output line_t                Pad,
    output logic                 PadValid
);

    // ----------------------------------------
    // Round helpers
    // ----------------------------------------

    // Rotate one 128-bit word left
    // Zero amount falls out as x since the right shift clears
    function automatic logic [LANE_BITS-1:0] rotl(
        input logic [LANE_BITS-1:0] x,
        input int unsigned          amt
    );
        return (x << amt) | (x >> (LANE_BITS - amt));
    endfunction

    // Entry state per lane
    // Seed repeated across the lane, lane index in the low byte
    function automatic line_t entryState(
        input logic [SEED_BITS-1:0] seed
    );
        line_t result;
        for (int l = 0; l < LANES; l++) begin
            result[l*LANE_BITS +: LANE_BITS] =
                {SEED_REPS{seed}} ^ LANE_BITS'(8'(l));
        end
        return result;
    endfunction

    // Toy round r
    // Lane XOR rotated key, then lane rotated left by one step
    function automatic line_t applyRound(
        input line_t               state,
        input logic [KEY_BITS-1:0] key,
        input int unsigned         r
    );
        line_t               result;
        logic [KEY_BITS-1:0] roundKey;
        roundKey = rotl(key, ROT_STEP * r);
        for (int l = 0; l < LANES; l++) begin
            result[l*LANE_BITS +: LANE_BITS] =
                rotl(state[l*LANE_BITS +: LANE_BITS] ^ roundKey, ROT_STEP);
        end
        return result;
    endfunction

    // ----------------------------------------
    // Pipeline slots
    // ----------------------------------------

    // Stage r holds the state after round r
    padStage_t stage     [ROUNDS];
    padStage_t nextStage [ROUNDS];

    always_comb begin
        // Round 0 works on the fresh entry state
        nextStage[0].valid = SeedValid;
        nextStage[0].key   = Key;
        nextStage[0].state = applyRound(entryState(Seed), Key, 0);

        // Later rounds use the key carried in the slot
        for (int r = 1; r < ROUNDS; r++) begin
            nextStage[r].valid = stage[r-1].valid;
            nextStage[r].key   = stage[r-1].key;
            nextStage[r].state = applyRound(stage[r-1].state, stage[r-1].key, r);
        end
    end

    // Shift every cycle, never stalls
    // Only the valid bits are cleared
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int r = 0; r < ROUNDS; r++) begin
                stage[r].valid <= 1'b0;
            end
        end else begin
            for (int r = 0; r < ROUNDS; r++) begin
                stage[r] <= nextStage[r];
            end
        end
    end

    // ----------------------------------------
    // Output from the last slot
    // ----------------------------------------

    // Valid twelve edges after the seed is taken
    assign Pad      = stage[ROUNDS-1].state;
    assign PadValid = stage[ROUNDS-1].valid;

endmodule

/* verilog/dataQueue.sv */
/* Plaintext data queue
   In-order circular buffer holding lines while their pads are generated */
module dataQueue
    import padPkg::*;
(
    input  logic  Clock,
    input  logic  rstN,
    input  line_t Plain,
    input  logic  Push,
    input  logic  Pop,
    output line_t Head
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // Line buffer
    line_t mem [QUEUE_DEPTH];

    // Write and read pointers
    // Power of two depth, so they wrap on their own
    logic [QUEUE_PTR_BITS-1:0] wrPtr;
    logic [QUEUE_PTR_BITS-1:0] rdPtr;

    // Write on push
    always_ff @(posedge Clock) begin
        if (Push) begin
            mem[wrPtr] <= Plain;
        end
    end

    // ----------------------------------------
    // Pointer control
    // ----------------------------------------

    // Push side advances once per request
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
        end else if (Push) begin
            wrPtr <= wrPtr + 1'b1;
        end
    end

    // Pop side advances once per finished pad
    // Pads come back in order, so the head always matches
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            rdPtr <= '0;
        end else if (Pop) begin
            rdPtr <= rdPtr + 1'b1;
        end
    end

    // ----------------------------------------
    // Head of queue
    // ----------------------------------------

    // Oldest line, readable the cycle after its push
    // At most 13 lines are held, well under the depth
    assign Head = mem[rdPtr];

endmodule

/* verilog/padCombiner.sv */
/* Pad combiner
   Registers pad XOR head plaintext and pops the queue for each pad */
module padCombiner
    import padPkg::*;
(
    input  logic  Clock,
    input  logic  rstN,
    input  line_t Pad,
    input  logic  PadValid,
    input  line_t Head,
    output logic  Pop,
    output line_t Cipher,
    output logic  CipherValid
);

    // ----------------------------------------
    // Queue handshake
    // ----------------------------------------

    // Every pad consumes exactly one line
    assign Pop = PadValid;

    // ----------------------------------------
    // Ciphertext register
    // ----------------------------------------

    // Keystream applied to the head line
    line_t cipherNext;

    assign cipherNext = Pad ^ Head;

    // Payload loads only with a pad
    always_ff @(posedge Clock) begin
        if (PadValid) begin
            Cipher <= cipherNext;
        end
    end

    // Valid follows the pad by one cycle
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            CipherValid <= 1'b0;
        end else begin
            CipherValid <= PadValid;
        end
    end

endmodule

/* verilog/cipherTop.sv */
/* Counter-mode encryption front end
   Latches the key and runs pad generation beside the plaintext queue */
module cipherTop
    import padPkg::*;
(
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic [KEY_BITS-1:0]  Key,
    input  logic                 KeyValid,
    input  logic [SEED_BITS-1:0] Seed,
    input  line_t                Plain,
    input  logic                 ReqValid,
    output line_t                DataOut,
    output logic                 DataOutValid
);

    // ----------------------------------------
    // Key register
    // ----------------------------------------

    // Current key for all new requests
    logic [KEY_BITS-1:0] keyReg;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            keyReg <= '0;
        end else if (KeyValid) begin
            keyReg <= Key;
        end
    end

    // ----------------------------------------
    // Request fan-out
    // ----------------------------------------

    // Incoming request bundle
    cipherReq_t req;

    assign req = '{valid: ReqValid, seed: Seed, plain: Plain};

    // Results into the combiner
    line_t pad;
    logic  padValid;
    line_t head;
    logic  pop;

    // Pad branch, fixed twelve-cycle latency
    padGenerator uPadGen (
        .Clock     (Clock),
        .rstN      (rstN),
        .Seed      (req.seed),
        .SeedValid (req.valid),
        .Key       (keyReg),
        .Pad       (pad),
        .PadValid  (padValid)
    );

    // Plaintext branch, pushed on the same strobe
    dataQueue uQueue (
        .Clock (Clock),
        .rstN  (rstN),
        .Plain (req.plain),
        .Push  (req.valid),
        .Pop   (pop),
        .Head  (head)
    );

    // Final XOR stage
    padCombiner uCombiner (
        .Clock       (Clock),
        .rstN        (rstN),
        .Pad         (pad),
        .PadValid    (padValid),
        .Head        (head),
        .Pop         (pop),
        .Cipher      (DataOut),
        .CipherValid (DataOutValid)
    );

endmodule

/* test/cipherTb.sv */
/* Testbench for the counter-mode encryption front end
   Replays the cases file and checks every ciphertext line and its latency */
module cipherTb
    import padPkg::*;
();

    // ----------------------------------------
    // DUT pins and run state
    // ----------------------------------------
    logic                 Clock;
    logic                 rstN;
    logic [KEY_BITS-1:0]  Key;
    logic                 KeyValid;
    logic [SEED_BITS-1:0] Seed;
    line_t                Plain;
    logic                 ReqValid;
    line_t                DataOut;
    logic                 DataOutValid;

    // Records from the cases file, one entry each
    logic [7:0]           recKind  [$];
    logic [KEY_BITS-1:0]  recKey   [$];
    logic [SEED_BITS-1:0] recSeed  [$];
    line_t                recPlain [$];
    line_t                recExp   [$];

    // Outstanding results, oldest first
    line_t expQ    [$];
    int    strobeQ [$];

    int     cycle       = 0;
    integer randSeed    = 14;
    logic   casesLoaded = 1'b0;

    cipherTop DUT (
        .Clock        (Clock),
        .rstN         (rstN),
        .Key          (Key),
        .KeyValid     (KeyValid),
        .Seed         (Seed),
        .Plain        (Plain),
        .ReqValid     (ReqValid),
        .DataOut      (DataOut),
        .DataOutValid (DataOutValid)
    );

    // Period 8
    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    // Edge count, read at the falling edge
    always @(posedge Clock) begin
        cycle <= cycle + 1;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    // Load the whole cases file before any stimulus
    task automatic readCases();
        integer               fd;
        integer               status;
        logic [8*8-1:0]       tag;
        logic [8*256-1:0]     skipLine;
        logic [KEY_BITS-1:0]  keyVal;
        logic [SEED_BITS-1:0] seedVal;
        line_t                plainVal;
        line_t                expVal;
        fd = $fopen("test/cipherCases.txt", "r");
        if (fd == 0) begin
            reportFailure("Cannot open the cases file test/cipherCases.txt");
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                // Rest of the line is a comment
                status = $fgets(skipLine, fd);
            end else if (tag == "K") begin
                status = $fscanf(fd, "%h", keyVal);
                assert (status == 1)
                else reportFailure("A key record in the cases file is incomplete");
                recKind.push_back(tag[7:0]);
                recKey.push_back(keyVal);
                recSeed.push_back('0);
                recPlain.push_back('0);
                recExp.push_back('0);
            end else if (tag == "R" || tag == "B") begin
                status = $fscanf(fd, "%h %h %h", seedVal, plainVal, expVal);
                assert (status == 3)
                else reportFailure("A request record in the cases file is incomplete");
                recKind.push_back(tag[7:0]);
                recKey.push_back('0);
                recSeed.push_back(seedVal);
                recPlain.push_back(plainVal);
                recExp.push_back(expVal);
            end else begin
                reportFailure("The cases file holds a record of unknown kind");
            end
        end
        $fclose(fd);
    endtask

    // Quiet cycles, strobes low
    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge Clock);
            ReqValid <= 1'b0;
            KeyValid <= 1'b0;
        end
    endtask

    task automatic loadKey(input logic [KEY_BITS-1:0] keyVal);
        @(posedge Clock);
        ReqValid <= 1'b0;
        Key      <= keyVal;
        KeyValid <= 1'b1;
    endtask

    // One-cycle request, result expected in order
    task automatic sendRequest(
        input logic [SEED_BITS-1:0] seedVal,
        input line_t                plainVal,
        input line_t                expVal
    );
        @(posedge Clock);
        KeyValid <= 1'b0;
        Seed     <= seedVal;
        Plain    <= plainVal;
        ReqValid <= 1'b1;
        expQ.push_back(expVal);
        // Edge count seen after this edge
        strobeQ.push_back(cycle + 1);
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        int gap;
        Key      = '0;
        KeyValid = 1'b0;
        Seed     = '0;
        Plain    = '0;
        ReqValid = 1'b0;
        rstN     = 1'b0;
        readCases();
        casesLoaded = 1'b1;

        // Reset for 16 cycles
        repeat (16) @(posedge Clock);
        rstN <= 1'b1;

        for (int i = 0; i < recKind.size(); i++) begin
            if (recKind[i] == "K") begin
                loadKey(recKey[i]);
            end else begin
                // B records follow the previous request with no gap
                if (recKind[i] == "R") begin
                    gap = $unsigned($random(randSeed)) % 4;
                    idleCycles(gap);
                end
                sendRequest(recSeed[i], recPlain[i], recExp[i]);
            end
        end
        idleCycles(1);

        // Drain, then watch for stray outputs
        while (expQ.size() != 0) @(negedge Clock);
        idleCycles(4);

        $display("TESTS PASSED");
        $finish;
    end

    // ----------------------------------------
    // Output checking
    // ----------------------------------------
    always @(negedge Clock) begin : checkOutput
        line_t expLine;
        int    strobeCycle;
        if (!rstN) begin
            assert (DataOutValid === 1'b0)
            else reportFailure("DataOutValid was not low during reset");
        end else if (DataOutValid !== 1'b0) begin
            assert (DataOutValid === 1'b1)
            else reportFailure("DataOutValid is unknown after reset");
            assert (expQ.size() > 0)
            else reportFailure("DataOutValid went high with no request outstanding");
            expLine     = expQ.pop_front();
            strobeCycle = strobeQ.pop_front();
            assert (DataOut === expLine)
            else reportFailure($sformatf("MISMATCH DataOut expected %h actual %h",
                                         expLine, DataOut));
            // Twelve rounds plus the combiner register
            assert (cycle - strobeCycle == ROUNDS + 1)
            else reportFailure($sformatf("Ciphertext came %0d cycles after its request, not %0d",
                                         cycle - strobeCycle, ROUNDS + 1));
        end
    end

    // Limit grows with the number of records
    initial begin : watchdog
        int limitCycles;
        wait (casesLoaded);
        limitCycles = recKind.size() * 4 + 13 + 32;
        repeat (limitCycles) @(posedge Clock);
        reportFailure($sformatf("Timeout after %0d cycles, the outputs never completed",
                                limitCycles));
    end

endmodule

/* list.f */
verilog/padPkg.sv
verilog/padGenerator.sv
verilog/dataQueue.sv
verilog/padCombiner.sv
verilog/cipherTop.sv
test/cipherTb.sv

/* test/cipherCases.txt */
# Columns: K key | R seed plain expected (random gap before) | B seed plain expected (no gap)
# All values hex, lines written lane 1 first, expected is plain XOR pad
K 000102030405060708090a0b0c0d0e0f
R 12345678 0000000000000000000000000000000000000000000000000000000000000000 1234567912345678123456781234567812345678123456781234567812345678
R deadbeef ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 2152411121524110215241102152411021524110215241102152411021524110
R 00000001 000000000000000000000000000000000000000000000000000000000000ff00 000000000000000100000001000000010000000100000001000000010000ff01
B 00000002 000000000000000000000000000000000000000000000000000000000000ff00 000000030000000200000002000000020000000200000002000000020000ff02
B 00000003 000000000000000000000000000000000000000000000000000000000000ff00 000000020000000300000003000000030000000300000003000000030000ff03
B 00000004 000000000000000000000000000000000000000000000000000000000000ff00 000000050000000400000004000000040000000400000004000000040000ff04
B 00000005 000000000000000000000000000000000000000000000000000000000000ff00 000000040000000500000005000000050000000500000005000000050000ff05
B 00000006 000000000000000000000000000000000000000000000000000000000000ff00 000000070000000600000006000000060000000600000006000000060000ff06
B 00000007 000000000000000000000000000000000000000000000000000000000000ff00 000000060000000700000007000000070000000700000007000000070000ff07
B 00000008 000000000000000000000000000000000000000000000000000000000000ff00 000000090000000800000008000000080000000800000008000000080000ff08
B 00000009 000000000000000000000000000000000000000000000000000000000000ff00 000000080000000900000009000000090000000900000009000000090000ff09
B 0000000a 000000000000000000000000000000000000000000000000000000000000ff00 0000000b0000000a0000000a0000000a0000000a0000000a0000000a0000ff0a
B 0000000b 000000000000000000000000000000000000000000000000000000000000ff00 0000000a0000000b0000000b0000000b0000000b0000000b0000000b0000ff0b
B 0000000c 000000000000000000000000000000000000000000000000000000000000ff00 0000000d0000000c0000000c0000000c0000000c0000000c0000000c0000ff0c
K ffeeddccbbaa99887766554433221100
R cafef00d 0000000000000000000000000000000000000000000000000000000000000000 cafef00ccafef00dcafef00dcafef00dcafef00dcafef00dcafef00dcafef00d
B cafef00d 0000000000000000000000008000000000000000000000000000000000000001 cafef00ccafef00dcafef00d4afef00dcafef00dcafef00dcafef00dcafef00c
K 0123456789abcdeffedcba9876543210
R ffffffff ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000100000000000000000000000000000000000000000000000000000000
R a5a5a5a5 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a fffffffeffffffffffffffffffffffffffffffffffffffffffffffffffffffff
B 00000000 0000000000000000000000000000000000000000000000000000000000000000 0000000100000000000000000000000000000000000000000000000000000000
